//--- lsu_pkg.sv
// shared sizes and encodings; fixed for a 4 KiB data memory of 64-bit words, not meant to vary
`default_nettype none

package lsu_pkg;

    localparam int XLEN      = 64;
    localparam int MEM_WORDS = 512;   // 4 KiB
    localparam int MEM_IDX_W = 9;

    // rv64i major opcodes
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 of the load/store group
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_D  = 3'b011;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;
    localparam logic [2:0] F3_WU = 3'b110;

    // access size, encoded as log2 of the byte count
    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } acc_size_e;

    // I-type layout, used by loads
    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // S-type layout, used by stores
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    // opcode and funct3 sit at the same bits in both views
    typedef union packed {
        i_type_t i_view;
        s_type_t s_view;
    } instr_u;

endpackage

`default_nettype wire

//--- lsu_ifs.sv
// memory and load tag bundles; rdata is the registered read word, valid one cycle after ren
`timescale 1ns/1ns
`default_nettype none

interface mem_if;
    import lsu_pkg::*;

    logic                 wen;
    logic                 ren;
    logic [MEM_IDX_W-1:0] idx;     // word index
    logic [7:0]           wmask;   // one bit per byte lane
    logic [XLEN-1:0]      wdata;   // already lane shifted
    logic [XLEN-1:0]      rdata;

    modport exe (output wen, ren, idx, wmask, wdata);
    modport mem (input wen, ren, idx, wmask, wdata, output rdata);
    modport res (input rdata);

endinterface

interface load_tag_if;
    import lsu_pkg::*;

    logic       valid;         // accepted load this cycle
    acc_size_e  size;
    logic       is_unsigned;
    logic [2:0] offset;        // byte offset in the word
    logic [4:0] rd;

    modport exe (output valid, size, is_unsigned, offset, rd);
    modport res (input valid, size, is_unsigned, offset, rd);

endinterface

`default_nettype wire

//--- ls_decode.sv
// decodes one rv64i load or store per cycle; illegal is a pulse only while issue is high
`timescale 1ns/1ns
`default_nettype none

module ls_decode (
    input  lsu_pkg::instr_u                  instr,
    input  logic                             issue,
    output logic                             is_load,
    output logic                             is_store,
    output lsu_pkg::acc_size_e               size,
    output logic                             is_unsigned,
    output logic [4:0]                       rd,
    output logic signed [lsu_pkg::XLEN-1:0]  imm,
    output logic                             illegal
);
    import lsu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       op_load;
    logic       op_store;
    logic       f3_load_ok;
    logic       f3_store_ok;
    logic       f3_unsigned;

    assign opcode   = instr.i_view.opcode;
    assign funct3   = instr.i_view.funct3;
    assign op_load  = (opcode == OP_LOAD);
    assign op_store = (opcode == OP_STORE);

    always_comb begin
        f3_load_ok  = 1'b1;
        f3_store_ok = 1'b1;
        f3_unsigned = 1'b0;
        case (funct3)
            F3_B:    size = SZ_B;
            F3_H:    size = SZ_H;
            F3_W:    size = SZ_W;
            F3_D:    size = SZ_D;
            F3_BU, F3_HU, F3_WU: begin
                size        = acc_size_e'(funct3[1:0]);
                f3_unsigned = 1'b1;
                f3_store_ok = 1'b0;   // no unsigned stores
            end
            default: begin
                size        = SZ_D;
                f3_load_ok  = 1'b0;
                f3_store_ok = 1'b0;
            end
        endcase
    end

    assign is_load     = op_load && f3_load_ok;
    assign is_store    = op_store && f3_store_ok;
    assign is_unsigned = op_load && f3_unsigned;
    assign rd          = instr.i_view.rd;
    assign illegal     = issue && !(is_load || is_store);

    // the opcode picks which view carries the immediate
    always_comb begin
        if (op_store) begin
            imm = {{(XLEN-12){instr.s_view.imm_11_5[6]}},
                   instr.s_view.imm_11_5, instr.s_view.imm_4_0};
        end else begin
            imm = {{(XLEN-12){instr.i_view.imm_11_0[11]}}, instr.i_view.imm_11_0};
        end
    end

endmodule

`default_nettype wire

//--- ls_execute.sv
// address, alignment and lane steering; misaligned accesses are flagged and dropped, never split
`timescale 1ns/1ns
`default_nettype none

module ls_execute (
    input  logic                             issue,
    input  logic                             is_load,
    input  logic                             is_store,
    input  lsu_pkg::acc_size_e               size,
    input  logic                             is_unsigned,
    input  logic [4:0]                       rd,
    input  logic signed [lsu_pkg::XLEN-1:0]  imm,
    input  logic [lsu_pkg::XLEN-1:0]         rs1_val,
    input  logic [lsu_pkg::XLEN-1:0]         rs2_val,
    output logic                             misaligned,
    mem_if.exe                               mem,
    load_tag_if.exe                          tag
);
    import lsu_pkg::*;

    logic [XLEN-1:0] addr;
    logic [2:0]      offset;
    logic            aligned;
    logic            access;
    logic            accept;
    logic [7:0]      byte_en;    // unshifted lanes for the size
    logic [XLEN-1:0] keep;
    logic [XLEN-1:0] st_data;

    assign addr   = rs1_val + imm;
    assign offset = addr[2:0];

    always_comb begin
        case (size)
            SZ_B: begin
                aligned = 1'b1;
                byte_en = 8'h01;
            end
            SZ_H: begin
                aligned = (offset[0] == 1'b0);
                byte_en = 8'h03;
            end
            SZ_W: begin
                aligned = (offset[1:0] == 2'b00);
                byte_en = 8'h0f;
            end
            default: begin
                aligned = (offset == 3'b000);
                byte_en = 8'hff;
            end
        endcase
    end

    // expand lane enables to a bit mask to clear the unused bytes of rs2
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            keep[8*b +: 8] = {8{byte_en[b]}};
        end
    end

    assign st_data = rs2_val & keep;

    assign access     = issue && (is_load || is_store);
    assign accept     = access && aligned;
    assign misaligned = access && !aligned;

    // word index wraps with the memory size
    assign mem.idx   = MEM_IDX_W'((addr >> 3) % MEM_WORDS);
    assign mem.wen   = accept && is_store;
    assign mem.ren   = accept && is_load;
    assign mem.wmask = byte_en << offset;
    assign mem.wdata = st_data << {offset, 3'b000};

    assign tag.valid       = accept && is_load;
    assign tag.size        = size;
    assign tag.is_unsigned = is_unsigned;
    assign tag.offset      = offset;
    assign tag.rd          = rd;

endmodule

`default_nettype wire

//--- data_mem.sv
// single port 512 x 64 data memory; contents are unspecified after reset, read is registered
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  logic clk,
    mem_if.mem   bus
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem_q [MEM_WORDS];

    // byte masked write
    always_ff @(posedge clk) begin
        if (bus.wen) begin
            for (int b = 0; b < 8; b++) begin
                if (bus.wmask[b]) begin
                    mem_q[bus.idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // rdata holds between loads
    always_ff @(posedge clk) begin
        if (bus.ren) begin
            bus.rdata <= mem_q[bus.idx];
        end
    end

endmodule

`default_nettype wire

//--- ls_result.sv
// load result one cycle after issue; no stall, the caller must take load_data when load_done is high
`timescale 1ns/1ns
`default_nettype none

module ls_result (
    input  logic                      clk,
    input  logic                      rst_n,
    mem_if.res                        bus,
    load_tag_if.res                   tag,
    output logic                      load_done,
    output logic [4:0]                load_rd,
    output logic [lsu_pkg::XLEN-1:0]  load_data
);
    import lsu_pkg::*;

    logic            valid_q;
    acc_size_e       size_q;
    logic            uns_q;
    logic [2:0]      offset_q;
    logic [4:0]      rd_q;
    logic [XLEN-1:0] shifted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= tag.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tag.valid) begin
            size_q   <= tag.size;
            uns_q    <= tag.is_unsigned;
            offset_q <= tag.offset;
            rd_q     <= tag.rd;
        end
    end

    assign shifted = bus.rdata >> {offset_q, 3'b000};   // addressed byte to lane 0

    always_comb begin
        case (size_q)
            SZ_B:    load_data = {{(XLEN-8){shifted[7] & ~uns_q}}, shifted[7:0]};
            SZ_H:    load_data = {{(XLEN-16){shifted[15] & ~uns_q}}, shifted[15:0]};
            SZ_W:    load_data = {{(XLEN-32){shifted[31] & ~uns_q}}, shifted[31:0]};
            default: load_data = shifted;   // ld
        endcase
    end

    assign load_done = valid_q;
    assign load_rd   = rd_q;

endmodule

`default_nettype wire

//--- lsu_top.sv
// rv64 load/store datapath; one instruction per issue pulse, loads answer one cycle later, no stall
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue,
    input  logic [31:0]               instr,
    input  logic [lsu_pkg::XLEN-1:0]  rs1_val,
    input  logic [lsu_pkg::XLEN-1:0]  rs2_val,
    output logic                      illegal,
    output logic                      misaligned,
    output logic                      load_done,
    output logic [4:0]                load_rd,
    output logic [lsu_pkg::XLEN-1:0]  load_data
);
    import lsu_pkg::*;

    instr_u                 instr_word;
    logic                   dec_load;
    logic                   dec_store;
    acc_size_e              dec_size;
    logic                   dec_unsigned;
    logic [4:0]             dec_rd;
    logic signed [XLEN-1:0] dec_imm;

    mem_if      i_mem_if ();
    load_tag_if i_tag_if ();

    assign instr_word = instr;

    ls_decode i_ls_decode (
        .instr       (instr_word),
        .issue       (issue),
        .is_load     (dec_load),
        .is_store    (dec_store),
        .size        (dec_size),
        .is_unsigned (dec_unsigned),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .illegal     (illegal)
    );

    ls_execute i_ls_execute (
        .issue       (issue),
        .is_load     (dec_load),
        .is_store    (dec_store),
        .size        (dec_size),
        .is_unsigned (dec_unsigned),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .misaligned  (misaligned),
        .mem         (i_mem_if.exe),
        .tag         (i_tag_if.exe)
    );

    data_mem i_data_mem (
        .clk (clk),
        .bus (i_mem_if.mem)
    );

    ls_result i_ls_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (i_mem_if.res),
        .tag       (i_tag_if.res),
        .load_done (load_done),
        .load_rd   (load_rd),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

//--- tb_clock.sv
// testbench clock of 100 ns and a reset held low for four rising edges, released 10 ns after one
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);
    localparam int PERIOD     = 100;
    localparam int RST_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;   // off the edge, like the other inputs
    end

endmodule

`default_nettype wire

//--- tb_lsu.sv
// directed testbench for lsu_top; the byte model expects loads to touch only bytes stored before
`timescale 1ns/1ns
`default_nettype none

module tb_lsu;

    localparam int          PERIOD       = 100;
    localparam int          DRIVE_DELAY  = 10;
    localparam int          SAMPLE_DELAY = 40;
    localparam int          RST_CYCLES   = 4;
    localparam logic [31:0] SEED         = 32'h99b0c495;
    localparam logic [6:0]  LOAD_OPC     = 7'b0000011;
    localparam logic [6:0]  STORE_OPC    = 7'b0100011;
    localparam logic [6:0]  BAD_OPS [4]  = '{7'b0010011, 7'b0110011, 7'b0000000, 7'b1111111};
    localparam int          RAND_WORDS   = 8;
    localparam int          N_RANDOM     = 300;
    // issue cycles per test, closing idle cycle included
    localparam int CYC_SIZES   = 31;
    localparam int CYC_LANES   = 7;
    localparam int CYC_MISAL   = 40;
    localparam int CYC_ILLEGAL = 12;
    localparam int CYC_RANDOM  = RAND_WORDS + N_RANDOM + 1;
    localparam int TIMEOUT_NS  = (RST_CYCLES + CYC_SIZES + CYC_LANES + CYC_MISAL
                                  + CYC_ILLEGAL + CYC_RANDOM) * PERIOD + 20 * PERIOD;

    logic        clk;
    logic        rst_n;
    logic        issue;
    logic [31:0] instr;
    logic [63:0] rs1_val;
    logic [63:0] rs2_val;
    logic        illegal;
    logic        misaligned;
    logic        load_done;
    logic [4:0]  load_rd;
    logic [63:0] load_data;

    logic [7:0]  ref_mem [4096];   // byte model of the data memory
    logic [31:0] lfsr = SEED;
    logic        pend_valid;       // load issued in the previous cycle
    logic [4:0]  pend_rd;
    logic [63:0] pend_data;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_err_base = 0;

    tb_clock i_tb_clock (.clk(clk), .rst_n(rst_n));

    lsu_top i_lsu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .instr      (instr),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .illegal    (illegal),
        .misaligned (misaligned),
        .load_done  (load_done),
        .load_rd    (load_rd),
        .load_data  (load_data)
    );

    // taps 32 22 2 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], next_rand_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_load(input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, LOAD_OPC};
    endfunction

    function automatic logic [31:0] enc_store(input logic [2:0] f3, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], STORE_OPC};
    endfunction

    // low n bytes of data go to the addressed bytes and the rest stay
    function automatic void model_store(input logic [63:0] addr, input logic [63:0] data,
                                        input int n);
        for (int i = 0; i < n; i++) begin
            ref_mem[addr[11:0] + 12'(i)] = data[8*i +: 8];
        end
    endfunction

    function automatic logic [63:0] model_load(input logic [63:0] addr, input int n,
                                               input logic uns);
        logic [63:0] v;
        logic        fill;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[addr[11:0] + 12'(i)];
        end
        fill = v[8*n-1] & !uns;
        for (int i = n; i < 8; i++) begin
            v[8*i +: 8] = {8{fill}};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h at %0t ns", name, got, exp, $time);
            error_count++;
        end
    endtask

    // one clock cycle that predicts, drives and checks this cycle's flags and last cycle's load
    task automatic issue_step(input logic go, input logic [31:0] ins, input logic [63:0] a,
                              input logic [63:0] b);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        ld_ok;
        logic        st_ok;
        logic [63:0] imm;
        logic [63:0] addr;
        int          n;
        logic        exp_ill;
        logic        exp_mis;
        logic        nxt_valid;
        opc   = ins[6:0];
        f3    = ins[14:12];
        ld_ok = (opc == LOAD_OPC) && (f3 != 3'b111);
        st_ok = (opc == STORE_OPC) && !f3[2];
        if (opc == STORE_OPC) imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        else imm = {{52{ins[31]}}, ins[31:20]};
        addr    = a + imm;
        n       = 1 << f3[1:0];
        exp_ill = go && !(ld_ok || st_ok);
        exp_mis = go && (ld_ok || st_ok) && ((addr[2:0] & 3'(n - 1)) != 3'b000);
        nxt_valid = go && ld_ok && !exp_mis;
        if (go && st_ok && !exp_mis) model_store(addr, b, n);
        @(posedge clk);
        #DRIVE_DELAY;
        issue   = go;
        instr   = ins;
        rs1_val = a;
        rs2_val = b;
        #SAMPLE_DELAY;
        check_value("illegal", 64'(illegal), 64'(exp_ill));
        check_value("misaligned", 64'(misaligned), 64'(exp_mis));
        check_value("load_done", 64'(load_done), 64'(pend_valid));
        if (pend_valid) begin
            check_value("load_rd", 64'(load_rd), 64'(pend_rd));
            check_value("load_data", load_data, pend_data);
        end
        pend_valid = nxt_valid;
        pend_rd    = ins[11:7];
        pend_data  = nxt_valid ? model_load(addr, n, f3[2]) : 64'h0;
    endtask

    task automatic idle_cycle();
        issue_step(1'b0, 32'h0, 64'h0, 64'h0);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_err_base) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: fail with %0d errors", name, error_count - test_err_base);
        end
    endtask

    task automatic test_sizes();
        int n;
        test_err_base = error_count;
        issue_step(1'b1, enc_store(3'b011, 5'd6, 5'd5, 12'h0), 64'h40, 64'h7182_e354_b7c6_a918);
        for (int k = 0; k < 7; k++) begin   // b h w d bu hu wu
            n = 1 << k[1:0];
            for (int off = 0; off < 8; off += n) begin
                issue_step(1'b1, enc_load(3'(k), 5'(3 * k + off + 1), 5'd5, 12'(off - 8)),
                           64'h48, 64'h0);
            end
        end
        idle_cycle();
        end_test("sizes and extension");
    endtask

    task automatic test_lanes();
        test_err_base = error_count;
        issue_step(1'b1, enc_store(3'b011, 5'd2, 5'd1, 12'h0), 64'h200, 64'h0011_2233_4455_6677);
        issue_step(1'b1, enc_store(3'b000, 5'd2, 5'd1, 12'h1), 64'h200, 64'hdead_beef_1234_565a);
        issue_step(1'b1, enc_store(3'b001, 5'd2, 5'd1, 12'h2), 64'h200, 64'hdead_beef_1234_c3d4);
        issue_step(1'b1, enc_load(3'b011, 5'd10, 5'd1, 12'h0), 64'h200, 64'h0);
        issue_step(1'b1, enc_store(3'b010, 5'd2, 5'd1, 12'h4), 64'h200, 64'hdead_beef_f00d_cafe);
        issue_step(1'b1, enc_load(3'b011, 5'd11, 5'd1, 12'h0), 64'h200, 64'h0);
        idle_cycle();
        end_test("byte lane masking");
    endtask

    task automatic test_misaligned();
        logic [63:0] base;
        base = 64'h300;
        test_err_base = error_count;
        issue_step(1'b1, enc_store(3'b011, 5'd4, 5'd3, 12'h0), base, rand_bits(64));
        for (int off = 1; off < 8; off++) begin
            issue_step(1'b1, enc_load(3'b011, 5'd7, 5'd3, 12'(off)), base, 64'h0);
            issue_step(1'b1, enc_store(3'b011, 5'd4, 5'd3, 12'(off)), base, rand_bits(64));
            if (off % 4 != 0) begin
                issue_step(1'b1, enc_load(3'b110, 5'd8, 5'd3, 12'(off)), base, 64'h0);
                issue_step(1'b1, enc_store(3'b010, 5'd4, 5'd3, 12'(off)), base, rand_bits(64));
            end
            if (off % 2 != 0) begin
                issue_step(1'b1, enc_load(3'b001, 5'd9, 5'd3, 12'(off)), base, 64'h0);
                issue_step(1'b1, enc_store(3'b001, 5'd4, 5'd3, 12'(off)), base, rand_bits(64));
            end
        end
        // held load and store words with issue low
        issue_step(1'b0, enc_load(3'b011, 5'd7, 5'd3, 12'h1), base, 64'h0);
        issue_step(1'b0, enc_store(3'b011, 5'd4, 5'd3, 12'h0), base, rand_bits(64));
        issue_step(1'b0, enc_load(3'b011, 5'd7, 5'd3, 12'h0), base, 64'h0);
        issue_step(1'b1, enc_load(3'b011, 5'd12, 5'd3, 12'h0), base, 64'h0);
        idle_cycle();
        end_test("misaligned accesses");
    endtask

    task automatic test_illegal();
        logic [31:0] ins;
        test_err_base = error_count;
        issue_step(1'b1, enc_store(3'b011, 5'd4, 5'd3, 12'h0), 64'h380, rand_bits(64));
        for (int k = 0; k < 4; k++) begin
            ins = enc_store(3'b011, 5'd4, 5'd3, 12'h0);
            ins[6:0] = BAD_OPS[k];
            issue_step(1'b1, ins, 64'h380, rand_bits(64));
        end
        issue_step(1'b1, enc_load(3'b111, 5'd13, 5'd3, 12'h0), 64'h380, 64'h0);
        for (int k = 4; k < 8; k++) begin
            issue_step(1'b1, enc_store(3'(k), 5'd4, 5'd3, 12'h0), 64'h380, rand_bits(64));
        end
        issue_step(1'b1, enc_load(3'b011, 5'd14, 5'd3, 12'h0), 64'h380, 64'h0);
        idle_cycle();
        end_test("illegal encodings");
    endtask

    // random ops in every cycle over the top 64 bytes with the high address bits wrapping away
    task automatic test_back_to_back();
        logic [11:0] base;
        logic [63:0] r;
        logic [63:0] tgt;
        logic [63:0] rs1;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic [2:0]  word;
        logic [2:0]  off;
        logic [2:0]  last_word;
        logic        is_st;
        logic [31:0] ins;
        base = 12'hfc0;
        last_word = 3'd0;
        test_err_base = error_count;
        for (int w = 0; w < RAND_WORDS; w++) begin
            issue_step(1'b1, enc_store(3'b011, 5'd2, 5'd1, 12'h0), 64'(base + 12'(8 * w)),
                       rand_bits(64));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            r = rand_bits(1);
            is_st = r[0];
            if (is_st) begin
                f3 = {1'b0, 2'(rand_bits(2))};
            end else begin
                f3 = 3'(rand_bits(3));
                if (f3 == 3'b111) f3 = 3'b011;
            end
            r = rand_bits(1);
            if (!is_st && r[0]) word = last_word;   // hit the word just stored
            else word = 3'(rand_bits(3));
            off   = 3'(rand_bits(3)) & ~3'((1 << f3[1:0]) - 1);
            imm12 = 12'(rand_bits(12));
            tgt   = 64'(base) + 64'({word, off});
            rs1   = tgt - {{52{imm12[11]}}, imm12} + (rand_bits(20) << 12);
            if (is_st) begin
                ins = enc_store(f3, 5'(rand_bits(5)), 5'(rand_bits(5)), imm12);
                last_word = word;
            end else begin
                ins = enc_load(f3, 5'(rand_bits(5)), 5'(rand_bits(5)), imm12);
            end
            issue_step(1'b1, ins, rs1, rand_bits(64));
        end
        idle_cycle();
        end_test("back to back traffic");
    endtask

    initial begin
        issue      = 1'b0;
        instr      = 32'h0;
        rs1_val    = 64'h0;
        rs2_val    = 64'h0;
        pend_valid = 1'b0;
        pend_rd    = 5'd0;
        pend_data  = 64'h0;
        @(posedge rst_n);
        test_sizes();
        test_lanes();
        test_misaligned();
        test_illegal();
        test_back_to_back();
        $display("tests passed %0d, failed %0d, check errors %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
lsu_pkg.sv
lsu_ifs.sv
ls_decode.sv
ls_execute.sv
data_mem.sv
ls_result.sv
lsu_top.sv
tb_clock.sv
tb_lsu.sv

//--- Makefile
TOP := tb_lsu
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile: $(OBJ)/V$(TOP)

$(OBJ)/V$(TOP): files.f $(wildcard *.sv)
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir $(OBJ) -f files.f

run: compile
	./$(OBJ)/V$(TOP) | tee run.log
	@if grep -q "TEST FAILED" run.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" run.log

clean:
	rm -rf $(OBJ) run.log
